/* textureSampler.f */
common/texturePkg.sv
common/samplerIfs.sv
src/samplerControl.sv
address/lodOffset.sv
address/texelAddressGen.sv
clamp/quadClamp.sv
src/textureSampler.sv
tests/textureSampler_chk.sv
tests/textureSamplerTb.sv

/* Bender.yml */
package:
  name: textureSampler

sources:
  - common/texturePkg.sv
  - common/samplerIfs.sv
  - src/samplerControl.sv
  - address/lodOffset.sv
  - address/texelAddressGen.sv
  - clamp/quadClamp.sv
  - src/textureSampler.sv
  - target: test
    files:
      - tests/textureSampler_chk.sv
      - tests/textureSamplerTb.sv

/* tests/textureSamplerTb.sv */
/*
 * Testbench of the texel-quad sampler.
 * Drives random and directed samples on the falling edge, models the texture
 * memory and predicts addresses, clamped texels and sub-texel positions.
 */
`timescale 1ns/1ps
`default_nettype none

module textureSamplerTb;

    localparam int MemDelay      = 2;
    localparam int PixelWidth    = 32;
    localparam int ClkPeriod     = 40;
    localparam int RandomCycles  = 48;
    localparam int SampleCount   = 2 * RandomCycles + 9;       // Random plus directed
    localparam int TimeoutCycles = SampleCount + 200;

    logic aclk;
    logic reset;
    logic sampleValid;
    logic enableHalfPixelOffset;
    logic clampS;
    logic clampT;
    logic texelRead;
    logic texelValid;
    texturePkg::sizeLog_t  textureSizeWidth;
    texturePkg::sizeLog_t  textureSizeHeight;
    texturePkg::sizeLog_t  textureLod;
    texturePkg::texCoord_t texelS;
    texturePkg::texCoord_t texelT;
    texturePkg::texAddr_t  texelAddr00;
    texturePkg::texAddr_t  texelAddr01;
    texturePkg::texAddr_t  texelAddr10;
    texturePkg::texAddr_t  texelAddr11;
    logic [PixelWidth-1:0] texelInput00;
    logic [PixelWidth-1:0] texelInput01;
    logic [PixelWidth-1:0] texelInput10;
    logic [PixelWidth-1:0] texelInput11;
    logic [PixelWidth-1:0] texel00;
    logic [PixelWidth-1:0] texel01;
    logic [PixelWidth-1:0] texel10;
    logic [PixelWidth-1:0] texel11;
    texturePkg::subCoord_t texelSubCoordS;
    texturePkg::subCoord_t texelSubCoordT;

    logic [4*PixelWidth-1:0]               memPipe [MemDelay+1];  // Read data in flight
    logic [4*texturePkg::TexAddrWidth-1:0] addrQ [$];             // Expected quad addresses
    logic [159:0]                          outQ [$];              // Expected texels, positions
    int                                    seed;
    string                                 testName;

    textureSampler #(.MemoryDelay(MemDelay), .PixelWidth(PixelWidth)) dut0 (.*);

    bind textureSampler textureSamplerChk #(.MemoryDelay(MemoryDelay)) protocolChk (
        .aclk(aclk), .reset(reset), .sampleValid(sampleValid),
        .texelRead(texelRead), .texelValid(texelValid));

    initial
    begin
        aclk = 1'b0;
        forever #(ClkPeriod / 2) aclk = ~aclk;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Memory content, every address bit reaches the word
    function automatic logic [PixelWidth-1:0] memWord(texturePkg::texAddr_t a);
        return {a[7:0], a[16:8], a[14:0]} ^ 32'hc3a5_0f96;
    endfunction

    function automatic int levelLog(int full, int lod);
        return (full > lod) ? full - lod : 0;   // Floored at 1 texel
    endfunction

    // Sum of the texel counts of all finer levels
    function automatic int levelBase(int w, int h, int lod);
        int total;
        total = 0;
        for (int n = 0; n < lod; n++)
            total += 1 << (levelLog(w, n) + levelLog(h, n));
        return total;
    endfunction

    function automatic logic inBounds(texturePkg::texCoord_t c, logic clamp);
        return (clamp != texturePkg::ClampToEdge) || (c >= 0 && c < 32'sh8000);
    endfunction

    function automatic int axisIndex(texturePkg::texCoord_t c, int lg);
        return int'(c & 32'h7fff) >> (15 - lg);     // Repeat keeps the fraction only
    endfunction

    function automatic texturePkg::subCoord_t subPosition(texturePkg::texCoord_t c, int lg);
        return texturePkg::subCoord_t'((c & 32'h7fff) << (lg + 1));
    endfunction

    // Self, then same row, same column, diagonal
    function automatic int nearestValid(int pos, logic [3:0] ok);
        int pick;
        pick = pos;
        for (int i = 3; i >= 0; i--)
        begin
            if (ok[pos ^ i])
                pick = pos ^ i;
        end
        return pick;
    endfunction

    task automatic predict(texturePkg::texCoord_t s, texturePkg::texCoord_t t,
                           logic cs, logic ct);
        texturePkg::texCoord_t sc [2];    // Quad columns
        texturePkg::texCoord_t tc [2];    // Quad rows
        texturePkg::texCoord_t stepS;
        texturePkg::texCoord_t stepT;
        texturePkg::texAddr_t  addr [4];
        logic [3:0]            ok;
        logic [PixelWidth-1:0] px [4];
        int                    lw;
        int                    lh;
        lw = levelLog(textureSizeWidth, textureLod);
        lh = levelLog(textureSizeHeight, textureLod);
        stepS = 32'sh8000 >>> lw;         // One level texel
        stepT = 32'sh8000 >>> lh;
        if (enableHalfPixelOffset)
        begin
            sc = '{s - stepS / 2, s + stepS / 2};
            tc = '{t - stepT / 2, t + stepT / 2};
        end
        else
        begin
            sc = '{s, s + stepS};
            tc = '{t, t + stepT};
        end
        for (int q = 0; q < 4; q++)
        begin
            addr[q] = texturePkg::texAddr_t'(levelBase(textureSizeWidth, textureSizeHeight,
                textureLod) + ((axisIndex(tc[q/2], lh) << lw) | axisIndex(sc[q%2], lw)));
            ok[q] = inBounds(sc[q%2], cs) && inBounds(tc[q/2], ct);
        end
        for (int q = 0; q < 4; q++)
            px[q] = memWord(addr[nearestValid(q, ok)]);
        addrQ.push_back({addr[0], addr[1], addr[2], addr[3]});
        outQ.push_back({px[0], px[1], px[2], px[3], subPosition(sc[0], lw),
                        subPosition(tc[0], lh)});
    endtask

    ////////////////////////////////////////
    // Memory model and checking
    ////////////////////////////////////////

    // Read data lands in time for the clamp register, MemDelay cycles after the read
    always @(negedge aclk)
    begin
        memPipe[0] <= {memWord(texelAddr00), memWord(texelAddr01),
                       memWord(texelAddr10), memWord(texelAddr11)};
        for (int i = 1; i <= MemDelay; i++)
            memPipe[i] <= memPipe[i-1];
    end

    assign {texelInput00, texelInput01, texelInput10, texelInput11} = memPipe[MemDelay];

    task automatic stopOnFailure();
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic checkWord(string field, logic [159:0] expected, logic [159:0] actual);
        assert (actual === expected)
        else
        begin
            $display("[ERROR] %s %s: expected %h, actual %h", testName, field,
                     expected, actual);
            stopOnFailure();
        end
    endtask

    always @(negedge aclk)
    begin
        assert (dut0.protocolChk.violationCount == 0)
        else
        begin
            $display("A valid pipeline assertion failed during %s", testName);
            stopOnFailure();
        end
        if (texelRead)
            checkWord("addresses", addrQ.pop_front(),
                      {texelAddr00, texelAddr01, texelAddr10, texelAddr11});
        if (texelValid)
            checkWord("quad", outQ.pop_front(), {texel00, texel01, texel10, texel11,
                                                 texelSubCoordS, texelSubCoordT});
    end

    initial
    begin
        #(TimeoutCycles * ClkPeriod);
        $display("Watchdog expired during %s, the DUT stopped returning quads", testName);
        stopOnFailure();
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    task automatic driveSample(logic valid, texturePkg::texCoord_t s,
                               texturePkg::texCoord_t t, logic cs, logic ct);
        @(negedge aclk);
        sampleValid = valid;
        texelS      = s;
        texelT      = t;
        clampS      = cs;
        clampT      = ct;
        if (valid)
            predict(s, t, cs, ct);
    endtask

    task automatic drain();
        @(negedge aclk);
        sampleValid = 1'b0;
        while (outQ.size() != 0)
            @(negedge aclk);
    endtask

    // Configuration only changes with the pipeline empty
    task automatic setConfig(int w, int h, int lod, logic half);
        drain();
        textureSizeWidth      = texturePkg::sizeLog_t'(w);
        textureSizeHeight     = texturePkg::sizeLog_t'(h);
        textureLod            = texturePkg::sizeLog_t'(lod);
        enableHalfPixelOffset = half;
    endtask

    task automatic randomPhase(string name, int cycles);
        logic valid;
        testName = name;
        for (int i = 0; i < cycles; i++)
        begin
            valid = ($random(seed) & 3) != 0;   // Roughly one idle cycle in four
            driveSample(valid, $random(seed) >>> 12, $random(seed) >>> 12, 1'b0, 1'b0);
        end
    endtask

    // Texel (0, 0) sits at the level base
    task automatic lodSample(int w, int h, int lod, int expectedBase);
        setConfig(w, h, lod, 1'b0);
        driveSample(1'b1, '0, '0, 1'b0, 1'b0);
        driveSample(1'b0, '0, '0, 1'b0, 1'b0);
        while (texelRead !== 1'b1)
            @(negedge aclk);
        checkWord("levelBase", expectedBase, texelAddr00);
    endtask

    initial
    begin
        seed        = 90;
        testName    = "reset";
        reset       = 1'b1;
        sampleValid = 1'b0;
        texelS      = '0;
        texelT      = '0;
        clampS      = 1'b0;
        clampT      = 1'b0;
        textureSizeWidth      = '0;
        textureSizeHeight     = '0;
        textureLod            = '0;
        enableHalfPixelOffset = 1'b0;
        foreach (memPipe[i])
            memPipe[i] = '0;
        repeat (16) @(negedge aclk);
        reset = 1'b0;

        setConfig(5, 3, 0, 1'b0);           // 32x8, wrapping
        randomPhase("lod0Repeat", RandomCycles);

        testName = "lodBase";
        lodSample(2, 2, 1, 16);
        lodSample(2, 2, 2, 20);
        lodSample(3, 1, 1, 16);
        lodSample(3, 1, 2, 20);
        lodSample(3, 1, 3, 22);

        setConfig(4, 4, 0, 1'b0);
        testName = "clampEdge";
        driveSample(1'b1, 32'sh7c00, 32'sh2000, 1'b1, 1'b1);    // Right edge
        driveSample(1'b1, 32'sh2000, 32'sh7c00, 1'b1, 1'b1);    // Bottom edge
        driveSample(1'b1, 32'sh7c00, 32'sh7e00, 1'b1, 1'b1);    // Corner
        driveSample(1'b1, -32'sh0100, 32'sh3000, 1'b1, 1'b1);   // Left of the texture

        setConfig(6, 5, 1, 1'b1);           // 32x16 level, centred quads
        randomPhase("halfPixel", RandomCycles);
        drain();

        if (dut0.protocolChk.violationCount == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/textureSampler_chk.sv */
/*
 * Protocol checks on the sampler valid pipeline, bound into textureSampler.
 * Covers the state after reset and the read and output latency.
 */
`timescale 1ns/1ps
`default_nettype none

module textureSamplerChk
#(
    parameter int unsigned MemoryDelay = 1
)
(
    input wire aclk,
    input wire reset,
    input wire sampleValid,
    input wire texelRead,
    input wire texelValid
);

    localparam int unsigned Stages = MemoryDelay + 3;

    int unsigned cyclesOutOfReset = 0;  // Saturates once the pipeline has refilled
    int          violationCount   = 0;  // Polled by the testbench

    always @(posedge aclk)
    begin
        if (reset)
            cyclesOutOfReset <= 0;
        else if (cyclesOutOfReset < Stages)
            cyclesOutOfReset <= cyclesOutOfReset + 1;
    end

    ////////////////////////////////////////
    // Reset and latency
    ////////////////////////////////////////
    resetClears: assert property (@(posedge aclk) reset |=> !texelRead && !texelValid)
    else
    begin
        $error("texelRead or texelValid high right after reset");
        violationCount++;
    end

    // Addresses leave two edges after the sample
    readLatency: assert property (@(posedge aclk) disable iff (reset)
        cyclesOutOfReset >= Stages |-> texelRead == $past(sampleValid, 2))
    else
    begin
        $error("texelRead does not follow sampleValid after 2 cycles");
        violationCount++;
    end

    validLatency: assert property (@(posedge aclk) disable iff (reset)
        cyclesOutOfReset >= Stages |-> texelValid == $past(sampleValid, Stages))
    else
    begin
        $error("texelValid does not follow sampleValid after MemoryDelay+3 cycles");
        violationCount++;
    end

endmodule

`default_nettype wire

/* src/textureSampler.sv */
/*
 * Bilinear texel-quad sampler, top level.
 * Takes one S16.15 coordinate pair per cycle, issues four texel reads to a
 * fixed delay memory and returns the clamped quad with its sub-texel position.
 * Latency is MemoryDelay+3 cycles, no back-pressure.
 */
`timescale 1ns/1ps
`default_nettype none

module textureSampler
#(
    parameter int unsigned MemoryDelay = 1,     // Memory read latency, 1 or more
    parameter int unsigned PixelWidth  = 32
)
(
    input  wire                          aclk,
    input  wire                          reset,

    input  wire                          sampleValid,
    input  texturePkg::sizeLog_t         textureSizeWidth,  // log2, quasi-static
    input  texturePkg::sizeLog_t         textureSizeHeight,
    input  texturePkg::sizeLog_t         textureLod,
    input  wire                          enableHalfPixelOffset,
    input  texturePkg::texCoord_t        texelS,            // S16.15
    input  texturePkg::texCoord_t        texelT,            // S16.15
    input  wire                          clampS,
    input  wire                          clampT,

    // Texture memory
    output logic                         texelRead,
    output texturePkg::texAddr_t         texelAddr00,
    output texturePkg::texAddr_t         texelAddr01,
    output texturePkg::texAddr_t         texelAddr10,
    output texturePkg::texAddr_t         texelAddr11,
    input  wire [PixelWidth-1:0]         texelInput00,
    input  wire [PixelWidth-1:0]         texelInput01,
    input  wire [PixelWidth-1:0]         texelInput10,
    input  wire [PixelWidth-1:0]         texelInput11,

    // Sampled quad
    output logic                         texelValid,
    output logic [PixelWidth-1:0]        texel00,
    output logic [PixelWidth-1:0]        texel01,
    output logic [PixelWidth-1:0]        texel10,
    output logic [PixelWidth-1:0]        texel11,
    output texturePkg::subCoord_t        texelSubCoordS,    // Q0.16
    output texturePkg::subCoord_t        texelSubCoordT
);

    lodStageIf lodStage();
    quadMaskIf quadMask();

    samplerControl #(.MemoryDelay(MemoryDelay)) control0 (
        .aclk(aclk), .reset(reset), .sampleValid(sampleValid),
        .texelRead(texelRead), .texelValid(texelValid));

    lodOffset lod0 (
        .aclk(aclk), .textureSizeWidth(textureSizeWidth),
        .textureSizeHeight(textureSizeHeight), .textureLod(textureLod),
        .enableHalfPixelOffset(enableHalfPixelOffset), .texelS(texelS),
        .texelT(texelT), .clampS(clampS), .clampT(clampT), .stage(lodStage.source));

    texelAddressGen addr0 (
        .aclk(aclk), .stage(lodStage.sink),
        .texelAddr00(texelAddr00), .texelAddr01(texelAddr01),
        .texelAddr10(texelAddr10), .texelAddr11(texelAddr11),
        .flags(quadMask.source));

    quadClamp #(.MemoryDelay(MemoryDelay), .PixelWidth(PixelWidth)) clamp0 (
        .aclk(aclk), .flags(quadMask.sink),
        .texelInput00(texelInput00), .texelInput01(texelInput01),
        .texelInput10(texelInput10), .texelInput11(texelInput11),
        .texel00(texel00), .texel01(texel01), .texel10(texel10), .texel11(texel11),
        .texelSubCoordS(texelSubCoordS), .texelSubCoordT(texelSubCoordT));

endmodule

`default_nettype wire

/* clamp/quadClamp.sv */
/*
 * Last sampler stage: clamp-to-edge on the returned texel quad.
 * Holds the edge flags and quad position for the memory delay, then
 * replaces every out-of-bounds member with an in-bounds neighbour.
 */
`timescale 1ns/1ps
`default_nettype none

module quadClamp
#(
    parameter int unsigned MemoryDelay = 1,
    parameter int unsigned PixelWidth  = 32
)
(
    input  wire                    aclk,
    quadMaskIf.sink                flags,
    input  wire [PixelWidth-1:0]   texelInput00,
    input  wire [PixelWidth-1:0]   texelInput01,
    input  wire [PixelWidth-1:0]   texelInput10,
    input  wire [PixelWidth-1:0]   texelInput11,
    output logic [PixelWidth-1:0]  texel00,
    output logic [PixelWidth-1:0]  texel01,
    output logic [PixelWidth-1:0]  texel10,
    output logic [PixelWidth-1:0]  texel11,
    output texturePkg::subCoord_t  texelSubCoordS,
    output texturePkg::subCoord_t  texelSubCoordT
);

    localparam int DelayWidth = 4 + 2 * texturePkg::SubCoordWidth;   // Flags plus positions

    // Member to use at position pos, nearest valid one first
    function automatic texturePkg::quadSel_t pickMember(texturePkg::quadSel_t pos,
                                                        logic [3:0] valid);
        if (valid[pos])
            return pos;
        else if (valid[pos ^ 2'b01])                // Same row
            return pos ^ 2'b01;
        else if (valid[pos ^ 2'b10])                // Same column
            return pos ^ 2'b10;
        else if (valid[pos ^ 2'b11])                // Diagonal
            return pos ^ 2'b11;
        return pos;                                 // Nothing valid, keep own texel
    endfunction

    logic [DelayWidth-1:0]      delayLine [MemoryDelay];
    logic                       validU0;
    logic                       validU1;
    logic                       validV0;
    logic                       validV1;
    texturePkg::subCoord_t      subCoordU;
    texturePkg::subCoord_t      subCoordV;
    logic [3:0]                 memberValid;    // Indexed by quadSel_t
    logic [PixelWidth-1:0]      texelIn  [4];
    logic [PixelWidth-1:0]      texelOut [4];

    ////////////////////////////////////////
    // Memory delay alignment
    ////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        delayLine[0] <= {flags.validU0, flags.validU1, flags.validV0, flags.validV1,
                         flags.subCoordU, flags.subCoordV};
        for (int i = 1; i < MemoryDelay; i++)
        begin
            delayLine[i] <= delayLine[i-1];
        end
    end

    assign {validU0, validU1, validV0, validV1, subCoordU, subCoordV} =
        delayLine[MemoryDelay-1];

    assign memberValid = {validV1 & validU1, validV1 & validU0,    // 11, 10
                          validV0 & validU1, validV0 & validU0};   // 01, 00

    assign texelIn[0] = texelInput00;
    assign texelIn[1] = texelInput01;
    assign texelIn[2] = texelInput10;
    assign texelIn[3] = texelInput11;

    ////////////////////////////////////////
    // Quad clamping
    ////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        for (int p = 0; p < 4; p++)
        begin
            texelOut[p] <= texelIn[pickMember(texturePkg::quadSel_t'(p), memberValid)];
        end
        texelSubCoordS <= subCoordU;
        texelSubCoordT <= subCoordV;
    end

    assign texel00 = texelOut[0];
    assign texel01 = texelOut[1];
    assign texel10 = texelOut[2];
    assign texel11 = texelOut[3];

endmodule

`default_nettype wire

/* address/texelAddressGen.sv */
/*
 * Second sampler stage: quad coordinates and memory addresses.
 * Applies the half-pixel offset, flags quad columns and rows outside the
 * texture under clamp-to-edge and derives the sub-texel position.
 */
`timescale 1ns/1ps
`default_nettype none

module texelAddressGen
(
    input  wire                    aclk,
    lodStageIf.sink                stage,
    output texturePkg::texAddr_t   texelAddr00,    // (s0, t0)
    output texturePkg::texAddr_t   texelAddr01,    // (s1, t0)
    output texturePkg::texAddr_t   texelAddr10,    // (s0, t1)
    output texturePkg::texAddr_t   texelAddr11,    // (s1, t1)
    quadMaskIf.source              flags
);

    localparam int IndexLsb = texturePkg::CoordFracBits - texturePkg::TexSizeBits;

    // One level texel in coordinate units, or half of one
    function automatic texturePkg::texCoord_t texelStep(texturePkg::sizeLog_t size,
                                                        logic half);
        return texturePkg::texCoord_t'(1) << (texturePkg::CoordFracBits - size - half);
    endfunction

    // In bounds when repeating, or when the integer part and sign are zero
    function automatic logic edgeValid(texturePkg::texCoord_t coord, logic clamp);
        return (clamp != texturePkg::ClampToEdge)
            || (coord[texturePkg::CoordWidth-1:texturePkg::CoordFracBits] == '0);
    endfunction

    // Top size bits of the fraction, the integer part falls away so repeat wraps
    function automatic logic [texturePkg::TexSizeBits-1:0] texelIndex(
        texturePkg::texCoord_t coord, texturePkg::sizeLog_t size);
        return coord[IndexLsb +: texturePkg::TexSizeBits] >> (texturePkg::TexSizeBits - size);
    endfunction

    function automatic texturePkg::texAddr_t quadAddr(
        logic [texturePkg::TexSizeBits-1:0] tIdx, logic [texturePkg::TexSizeBits-1:0] sIdx);
        return stage.offset + ((texturePkg::texAddr_t'(tIdx) << stage.levelWidth)
                               | texturePkg::texAddr_t'(sIdx));
    endfunction

    texturePkg::texCoord_t s0;
    texturePkg::texCoord_t s1;
    texturePkg::texCoord_t t0;
    texturePkg::texCoord_t t1;

    ////////////////////////////////////////
    // Quad coordinates
    ////////////////////////////////////////
    always_comb
    begin
        if (stage.halfPixel)
        begin
            s0 = stage.texelS - texelStep(stage.levelWidth, 1'b1);    // Centre on the quad
            s1 = stage.texelS + texelStep(stage.levelWidth, 1'b1);
            t0 = stage.texelT - texelStep(stage.levelHeight, 1'b1);
            t1 = stage.texelT + texelStep(stage.levelHeight, 1'b1);
        end
        else
        begin
            s0 = stage.texelS;
            s1 = stage.texelS + texelStep(stage.levelWidth, 1'b0);
            t0 = stage.texelT;
            t1 = stage.texelT + texelStep(stage.levelHeight, 1'b0);
        end
    end

    always_ff @(posedge aclk)
    begin
        texelAddr00 <= quadAddr(texelIndex(t0, stage.levelHeight), texelIndex(s0, stage.levelWidth));
        texelAddr01 <= quadAddr(texelIndex(t0, stage.levelHeight), texelIndex(s1, stage.levelWidth));
        texelAddr10 <= quadAddr(texelIndex(t1, stage.levelHeight), texelIndex(s0, stage.levelWidth));
        texelAddr11 <= quadAddr(texelIndex(t1, stage.levelHeight), texelIndex(s1, stage.levelWidth));

        flags.validU0 <= edgeValid(s0, stage.clampS);
        flags.validU1 <= edgeValid(s1, stage.clampS);
        flags.validV0 <= edgeValid(t0, stage.clampT);
        flags.validV1 <= edgeValid(t1, stage.clampT);

        // Fraction below the texel index, scaled up to a full Q0.16
        flags.subCoordU <= texturePkg::subCoord_t'(
            {s0[texturePkg::CoordFracBits-1:0], 1'b0} << stage.levelWidth);
        flags.subCoordV <= texturePkg::subCoord_t'(
            {t0[texturePkg::CoordFracBits-1:0], 1'b0} << stage.levelHeight);
    end

endmodule

`default_nettype wire

/* address/lodOffset.sv */
/*
 * First sampler stage: size and base address of the selected mip level.
 * Registers them together with the coordinates and clamp modes.
 */
`timescale 1ns/1ps
`default_nettype none

module lodOffset
(
    input  wire                    aclk,
    input  texturePkg::sizeLog_t   textureSizeWidth,   // log2 of the base width
    input  texturePkg::sizeLog_t   textureSizeHeight,
    input  texturePkg::sizeLog_t   textureLod,
    input  wire                    enableHalfPixelOffset,
    input  texturePkg::texCoord_t  texelS,
    input  texturePkg::texCoord_t  texelT,
    input  wire                    clampS,
    input  wire                    clampT,
    lodStageIf.source              stage
);

    localparam int MaskSize   = texturePkg::TexSizeBits + 1;   // One axis
    localparam int MaskStSize = 2 * MaskSize;                  // Both axes interleaved
    localparam logic [MaskSize-1:0]   MaskOne   = MaskSize'(1);
    localparam logic [MaskStSize-1:0] MaskStOne = MaskStSize'(1);

    texturePkg::sizeLog_t   levelWidth;
    texturePkg::sizeLog_t   levelHeight;
    logic [MaskSize-1:0]    wMask;
    logic [MaskSize-1:0]    hMask;
    logic [MaskStSize-1:0]  mask;
    logic [MaskStSize-1:0]  maskFin;
    logic [MaskStSize-1:0]  lodMask;

    // Texel count of level n is 2^(w+h-2n), so the sum over all finer levels
    // is a bit pattern built from the two axis masks, one bit pair per level
    always_comb
    begin
        levelWidth  = (textureLod < textureSizeWidth) ? textureSizeWidth - textureLod : '0;
        levelHeight = (textureLod < textureSizeHeight) ? textureSizeHeight - textureLod : '0;

        wMask = (MaskOne << textureSizeWidth) - MaskOne;
        hMask = (MaskOne << textureSizeHeight) - MaskOne;
        for (int i = 0; i < MaskSize; i++)
        begin
            mask[MaskStSize - 1 - 2 * i] = wMask[i] | hMask[i];   // Square level
            mask[MaskStSize - 2 - 2 * i] = wMask[i] ^ hMask[i];   // Only one axis left
        end
        maskFin = mask >> (MaskStSize - (textureSizeWidth + textureSizeHeight + 1));

        // Drop the levels at and below the selected one
        lodMask = ~((MaskStOne << (levelWidth + levelHeight + 1)) - MaskStOne);
    end

    always_ff @(posedge aclk)
    begin
        stage.offset      <= texturePkg::texAddr_t'(maskFin & lodMask);
        stage.levelWidth  <= levelWidth;
        stage.levelHeight <= levelHeight;
        stage.texelS      <= texelS;
        stage.texelT      <= texelT;
        stage.clampS      <= clampS;
        stage.clampT      <= clampT;
        stage.halfPixel   <= enableHalfPixelOffset;
    end

endmodule

`default_nettype wire

/* src/samplerControl.sv */
/*
 * Valid pipeline of the sampler.
 * Follows each sample through the datapath and marks the cycle of
 * its memory read and the cycle of its output quad.
 */
`timescale 1ns/1ps
`default_nettype none

module samplerControl
#(
    parameter int unsigned MemoryDelay = 1
)
(
    input  wire  aclk,
    input  wire  reset,
    input  wire  sampleValid,
    output logic texelRead,     // With the quad addresses
    output logic texelValid     // With the clamped quad
);

    // Stage layout, one bit per datapath register:
    //   0              level offset
    //   1              quad addresses
    //   2..M+1         memory delay
    //   M+2            clamped quad
    localparam int unsigned Stages = MemoryDelay + 3;

    logic [Stages-1:0] validPipe;

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            validPipe <= '0;
        end
        else
        begin
            validPipe <= {validPipe[Stages-2:0], sampleValid};  // Shift in new sample
        end
    end

    assign texelRead  = validPipe[1];
    assign texelValid = validPipe[Stages-1];

endmodule

`default_nettype wire

/* common/samplerIfs.sv */
/*
 * Stage interfaces between the sampler datapath blocks.
 * lodStageIf carries the level data from lodOffset to texelAddressGen,
 * quadMaskIf the edge flags and quad position to quadClamp.
 */
`timescale 1ns/1ps
`default_nettype none

interface lodStageIf;
    texturePkg::texAddr_t  offset;      // Base address of the mip level
    texturePkg::sizeLog_t  levelWidth;  // log2 of the level width
    texturePkg::sizeLog_t  levelHeight;
    texturePkg::texCoord_t texelS;      // S16.15
    texturePkg::texCoord_t texelT;      // S16.15
    logic                  clampS;
    logic                  clampT;
    logic                  halfPixel;

    modport source (output offset, levelWidth, levelHeight, texelS, texelT,
                    clampS, clampT, halfPixel);
    modport sink   (input offset, levelWidth, levelHeight, texelS, texelT,
                    clampS, clampT, halfPixel);
endinterface

// Per axis flags, low when that quad column or row lies outside under clamping
interface quadMaskIf;
    logic                  validU0;     // Left column
    logic                  validU1;     // Right column
    logic                  validV0;     // Top row
    logic                  validV1;     // Bottom row
    texturePkg::subCoord_t subCoordU;   // Q0.16
    texturePkg::subCoord_t subCoordV;   // Q0.16

    modport source (output validU0, validU1, validV0, validV1, subCoordU, subCoordV);
    modport sink   (input validU0, validU1, validV0, validV1, subCoordU, subCoordV);
endinterface

`default_nettype wire

/* common/texturePkg.sv */
/*
 * Shared widths and types of the bilinear texel-quad sampler.
 * Modules and interfaces refer to these by scoped names.
 * Texture axes are powers of two up to 256 texels; all mip levels
 * live in one linear texel address space.
 */
`default_nettype none

package texturePkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int TexSizeBits   = 8;   // Index bits per axis, 256 texels max
    localparam int SizeLogWidth  = 4;   // log2 size or LOD
    localparam int TexAddrWidth  = 17;  // 256x256 plus the smaller mip levels
    localparam int CoordWidth    = 32;  // S16.15
    localparam int CoordFracBits = 15;
    localparam int SubCoordWidth = 16;  // Q0.16

    // Clamp mode per axis, the other value selects repeat
    localparam logic ClampToEdge = 1'b1;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    // log2 of a texture dimension, also used for the LOD
    typedef logic [SizeLogWidth-1:0] sizeLog_t;

    // Normalized texture coordinate, 1.0 spans the whole level
    typedef logic signed [CoordWidth-1:0] texCoord_t;

    typedef logic [TexAddrWidth-1:0] texAddr_t;     // Texel word address

    // Position inside the quad, 0x0000 .. 0xffff
    typedef logic [SubCoordWidth-1:0] subCoord_t;

    // Quad member select, bit 0 picks the column and bit 1 the row
    //   00 01
    //   10 11
    typedef logic [1:0] quadSel_t;

endpackage

`default_nettype wire
